//--- source/i2s_defs.svh
/*
 * shared widths, frame size and register map of the I2S bus master.
 * included by the package and by every module that needs a width or an offset.
 */
`ifndef I2S_DEFS_SVH
`define I2S_DEFS_SVH

// audio and bus widths.
`define I2S_DATA_BITS   16
`define I2S_WORD_BITS   32
`define I2S_FRAME_SLOTS 32
`define I2S_COUNT_BITS  6
`define I2S_ADDR_BITS   4

// register offsets, one 32-bit word apart.
`define I2S_REG_CTRL    4'd0
`define I2S_REG_STATUS  4'd4
`define I2S_REG_TX_DATA 4'd8
`define I2S_REG_RX_DATA 4'd12

// control register bits.
`define I2S_CTRL_TX_EN 0
`define I2S_CTRL_RX_EN 1
`define I2S_CTRL_EN    2

// status register bits.
`define I2S_STAT_TX_UNDERFLOW 0
`define I2S_STAT_TX_NOT_FULL  1
`define I2S_STAT_RX_OVERFLOW  2
`define I2S_STAT_RX_NOT_EMPTY 3

`endif

//--- source/i2s_pkg.sv
/*
 * types shared by the I2S master blocks.
 * a stereo word is seen raw by the register block and per channel by the
 * serializers, so it is carried as a packed union.
 */
`include "i2s_defs.svh"

package i2s_pkg;

    // left channel sits in the upper half of the word.
    typedef struct packed {
        logic [`I2S_DATA_BITS-1:0] left;
        logic [`I2S_DATA_BITS-1:0] right;
    } i2s_stereo_t;

    typedef union packed {
        logic [`I2S_WORD_BITS-1:0] raw;
        i2s_stereo_t               ch;
    } i2s_sample_u;

    // slot index within one frame.
    typedef logic [`I2S_COUNT_BITS-2:0] i2s_slot_t;

endpackage

//--- source/i2s_regs.sv
/*
 * AXI4-Lite slave of the I2S master.
 * holds the control register, builds the status word and turns accesses to
 * the data ports into push and pop strobes on the two sample FIFOs.
 * a write to a full tx FIFO is dropped, a read of an empty rx FIFO gives zero.
 */
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_regs import i2s_pkg::*; (
    input  logic                      op_clk,
    input  logic                      reset,
    input  logic                      awvalid,
    input  logic [`I2S_ADDR_BITS-1:0] awaddr,
    output logic                      awready,
    input  logic                      wvalid,
    input  logic [`I2S_WORD_BITS-1:0] wdata,
    input  logic [3:0]                wstrb,
    output logic                      wready,
    output logic                      bvalid,
    output logic [1:0]                bresp,
    input  logic                      bready,
    input  logic                      arvalid,
    input  logic [`I2S_ADDR_BITS-1:0] araddr,
    output logic                      arready,
    output logic                      rvalid,
    output logic [`I2S_WORD_BITS-1:0] rdata,
    output logic [1:0]                rresp,
    input  logic                      rready,
    output logic                      enable,
    output logic                      tx_enable,
    output logic                      rx_enable,
    output logic                      tx_push,
    output i2s_sample_u               tx_push_data,
    input  logic                      tx_push_ready,
    output logic                      rx_pop,
    input  i2s_sample_u               rx_pop_data,
    input  logic                      rx_pop_valid,
    input  logic                      tx_underflow,
    input  logic                      rx_overflow
);

    // one pulse accepts address and data together.
    logic                      wr_ready;
    logic [`I2S_WORD_BITS-1:0] ctrl_word;
    logic [`I2S_WORD_BITS-1:0] status_word;

    assign awready = wr_ready;
    assign wready  = wr_ready;
    // every access completes with OKAY.
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // the tx data port feeds the FIFO directly.
    assign tx_push_data.raw = wdata;
    assign tx_push = wr_ready && (awaddr == `I2S_REG_TX_DATA) && tx_push_ready;
    // pop only when a word is there to return.
    assign rx_pop = arready && (araddr == `I2S_REG_RX_DATA) && rx_pop_valid;

    always_comb
    begin
        ctrl_word = '0;
        ctrl_word[`I2S_CTRL_TX_EN] = tx_enable;
        ctrl_word[`I2S_CTRL_RX_EN] = rx_enable;
        ctrl_word[`I2S_CTRL_EN] = enable;
        // sticky errors next to the live FIFO levels.
        status_word = '0;
        status_word[`I2S_STAT_TX_UNDERFLOW] = tx_underflow;
        status_word[`I2S_STAT_TX_NOT_FULL] = tx_push_ready;
        status_word[`I2S_STAT_RX_OVERFLOW] = rx_overflow;
        status_word[`I2S_STAT_RX_NOT_EMPTY] = rx_pop_valid;
    end

    always_ff @(posedge op_clk)
    begin
        if (reset)
        begin
            wr_ready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            enable <= 1'b0;
            tx_enable <= 1'b0;
            rx_enable <= 1'b0;
        end
        else
        begin
            // no new write while a response is still pending.
            wr_ready <= !wr_ready && awvalid && wvalid && !bvalid;
            if (wr_ready)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            arready <= !arready && arvalid && !rvalid;
            if (arready)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
            // control bits all live in the low byte.
            if (wr_ready && (awaddr == `I2S_REG_CTRL) && wstrb[0])
            begin
                enable <= wdata[`I2S_CTRL_EN];
                tx_enable <= wdata[`I2S_CTRL_TX_EN];
                rx_enable <= wdata[`I2S_CTRL_RX_EN];
            end
        end
    end

    // read data is latched with the address handshake.
    always_ff @(posedge op_clk)
    begin
        if (arready)
        begin
            case (araddr)
                `I2S_REG_CTRL:    rdata <= ctrl_word;
                `I2S_REG_STATUS:  rdata <= status_word;
                `I2S_REG_RX_DATA: rdata <= rx_pop_valid ? rx_pop_data.raw : '0;
                default:          rdata <= '0;
            endcase
        end
    end

endmodule

//--- source/i2s_sample_fifo.sv
/*
 * synchronous FIFO of stereo words with a show-ahead read port.
 * push and pop are one-cycle strobes, push_ready and pop_valid are levels.
 * one instance per direction.
 */
`timescale 1ns/1ps

module i2s_sample_fifo import i2s_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic        op_clk,
    input  logic        reset,
    input  logic        push,
    input  i2s_sample_u push_data,
    output logic        push_ready,
    input  logic        pop,
    output i2s_sample_u pop_data,
    output logic        pop_valid
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    i2s_sample_u         mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // circular pointers, wrap at depth.
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready = (count != CNT_BITS'(DEPTH));
    assign pop_valid = (count != '0);
    assign do_push = push && push_ready;
    assign do_pop = pop && pop_valid;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge op_clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            // level only moves when one side acts alone.
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge op_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

//--- source/i2s_frame_timer.sv
/*
 * bit counter of the I2S master.
 * a 64-cycle down-counter gives sck, ws, the slot index and the strobes that
 * the serializers run on. it parks at its top value while disabled.
 */
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_frame_timer import i2s_pkg::*; (
    input  logic      op_clk,
    input  logic      reset,
    input  logic      enable,
    output logic      sck,
    output logic      ws,
    output logic      frame_start,
    output logic      shift_edge,
    output i2s_slot_t slot
);

    localparam logic [`I2S_COUNT_BITS-1:0] TOP = `I2S_COUNT_BITS'(2 * `I2S_FRAME_SLOTS - 1);

    logic [`I2S_COUNT_BITS-1:0] count;

    // two cycles per slot, wraps from zero back to the top.
    always_ff @(posedge op_clk)
    begin
        if (reset || !enable)
            count <= TOP;
        else
            count <= count - 1'b1;
    end

    // slot counts up while the counter counts down.
    assign slot = ~count[`I2S_COUNT_BITS-1:1];
    // sck low in the first cycle of a slot, high in the second.
    assign sck = ~count[0];
    // ws straight from a counter flop: left half low, right half high.
    assign ws = ~count[`I2S_COUNT_BITS-1];
    // parked top value is the first cycle of slot 0 once enabled.
    assign frame_start = enable && (count == TOP);
    // sck falls at the end of this cycle.
    assign shift_edge = enable && !count[0];

endmodule

//--- source/i2s_tx_serializer.sv
/*
 * transmit side of the I2S master.
 * starts on a frame boundary, pops one stereo word per frame and shifts the
 * left half, then the right half, MSB first with the one-slot I2S delay.
 * an empty FIFO at a frame start sets a sticky underflow and stops tx.
 */
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_tx_serializer import i2s_pkg::*; (
    input  logic        op_clk,
    input  logic        reset,
    input  logic        enable,
    input  logic        tx_enable,
    input  logic        frame_start,
    input  logic        shift_edge,
    input  i2s_slot_t   slot,
    output logic        pop,
    input  i2s_sample_u pop_data,
    input  logic        pop_valid,
    output logic        sdo,
    output logic        underflow
);

    logic        tx_active;
    logic        tx_go;
    logic        load;
    logic        tx_bit;
    i2s_sample_u word;

    // tx may run only while enabled and free of underflow.
    assign tx_go = enable && tx_enable && !underflow;
    // a word is needed at every left-channel start.
    assign load = frame_start && tx_go;
    assign pop = load && pop_valid;
    // upper slot half drives the right channel.
    assign tx_bit = slot[`I2S_COUNT_BITS-2] ? word.ch.right[`I2S_DATA_BITS-1]
                                            : word.ch.left[`I2S_DATA_BITS-1];

    always_ff @(posedge op_clk)
    begin
        if (reset)
        begin
            tx_active <= 1'b0;
            underflow <= 1'b0;
            sdo <= 1'b0;
        end
        else
        begin
            // sticky until tx_enable is cleared.
            underflow <= (underflow || (load && !pop_valid)) && tx_enable;
            if (!tx_go)
                tx_active <= 1'b0;
            else if (frame_start)
                tx_active <= pop_valid;
            // bit for slot s+1 goes out at the end of slot s.
            if (!tx_go)
                sdo <= 1'b0;
            else if (shift_edge)
                sdo <= tx_active && tx_bit;
        end
    end

    always_ff @(posedge op_clk)
    begin
        if (pop)
            word <= pop_data;
        else if (shift_edge && tx_active)
        begin
            // each half shifts only during its own slots.
            if (slot[`I2S_COUNT_BITS-2])
                word.ch.right <= word.ch.right << 1;
            else
                word.ch.left <= word.ch.left << 1;
        end
    end

endmodule

//--- source/i2s_rx_deserializer.sv
/*
 * receive side of the I2S master.
 * samples sdi at each shift edge into a stereo word, left in slots 1 to 16
 * and right in slots 17 to 0, and pushes it after slot 0 of the next frame.
 * a push into a full FIFO loses the word, sets a sticky overflow and stops rx.
 */
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_rx_deserializer import i2s_pkg::*; (
    input  logic        op_clk,
    input  logic        reset,
    input  logic        enable,
    input  logic        rx_enable,
    input  logic        frame_start,
    input  logic        shift_edge,
    input  i2s_slot_t   slot,
    input  logic        sdi,
    output logic        push,
    output i2s_sample_u push_data,
    input  logic        push_ready,
    output logic        overflow
);

    logic        rx_active;
    logic        started;
    logic        push_q;
    logic        rx_go;
    i2s_slot_t   bit_slot;
    i2s_sample_u word;

    assign rx_go = enable && rx_enable && !overflow;
    // data lags ws by one slot, so count bits from slot 1.
    assign bit_slot = slot - 1'b1;
    assign push = push_q && push_ready;
    assign push_data = word;

    always_ff @(posedge op_clk)
    begin
        if (reset)
        begin
            rx_active <= 1'b0;
            started <= 1'b0;
            push_q <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            // sticky until rx_enable is cleared.
            overflow <= (overflow || (push_q && !push_ready)) && rx_enable;
            if (!rx_go)
                rx_active <= 1'b0;
            else if (frame_start)
                rx_active <= 1'b1;
            // a word counts once its MSB in slot 1 has been taken.
            if (!rx_active)
                started <= 1'b0;
            else if (shift_edge && (slot == i2s_slot_t'(1)))
                started <= 1'b1;
            // last bit sits in slot 0 of the following frame.
            push_q <= rx_active && started && shift_edge && (slot == '0);
        end
    end

    always_ff @(posedge op_clk)
    begin
        if (shift_edge && rx_active)
        begin
            if (bit_slot[`I2S_COUNT_BITS-2])
                word.ch.right <= {word.ch.right[`I2S_DATA_BITS-2:0], sdi};
            else
                word.ch.left <= {word.ch.left[`I2S_DATA_BITS-2:0], sdi};
        end
    end

endmodule

//--- source/i2s_master.sv
/*
 * top level of the I2S bus master.
 * AXI4-Lite register block, bit counter, tx and rx serializers and one
 * sample FIFO per direction. one 32-bit word is one stereo pair.
 */
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_master import i2s_pkg::*; (
    input  logic                      op_clk,
    input  logic                      reset,
    input  logic                      sdi,
    output logic                      sck,
    output logic                      ws,
    output logic                      sdo,
    input  logic                      awvalid,
    input  logic [`I2S_ADDR_BITS-1:0] awaddr,
    output logic                      awready,
    input  logic                      wvalid,
    input  logic [`I2S_WORD_BITS-1:0] wdata,
    input  logic [3:0]                wstrb,
    output logic                      wready,
    output logic                      bvalid,
    output logic [1:0]                bresp,
    input  logic                      bready,
    input  logic                      arvalid,
    input  logic [`I2S_ADDR_BITS-1:0] araddr,
    output logic                      arready,
    output logic                      rvalid,
    output logic [`I2S_WORD_BITS-1:0] rdata,
    output logic [1:0]                rresp,
    input  logic                      rready
);

    // control and sticky status.
    logic        enable;
    logic        tx_enable;
    logic        rx_enable;
    logic        tx_underflow;
    logic        rx_overflow;
    // tx FIFO, filled from the bus.
    logic        tx_push;
    logic        tx_push_ready;
    logic        tx_pop;
    logic        tx_pop_valid;
    i2s_sample_u tx_push_data;
    i2s_sample_u tx_pop_data;
    // rx FIFO, drained by the bus.
    logic        rx_push;
    logic        rx_push_ready;
    logic        rx_pop;
    logic        rx_pop_valid;
    i2s_sample_u rx_push_data;
    i2s_sample_u rx_pop_data;
    // frame timing.
    logic        frame_start;
    logic        shift_edge;
    i2s_slot_t   slot;

    // port names match the wires above.
    i2s_regs regs_inst (.*);

    i2s_frame_timer frame_timer_inst (.*);

    i2s_sample_fifo tx_fifo_inst (
        .op_clk(op_clk),
        .reset(reset),
        .push(tx_push),
        .push_data(tx_push_data),
        .push_ready(tx_push_ready),
        .pop(tx_pop),
        .pop_data(tx_pop_data),
        .pop_valid(tx_pop_valid)
    );

    i2s_sample_fifo rx_fifo_inst (
        .op_clk(op_clk),
        .reset(reset),
        .push(rx_push),
        .push_data(rx_push_data),
        .push_ready(rx_push_ready),
        .pop(rx_pop),
        .pop_data(rx_pop_data),
        .pop_valid(rx_pop_valid)
    );

    i2s_tx_serializer tx_inst (
        .*,
        .pop(tx_pop),
        .pop_data(tx_pop_data),
        .pop_valid(tx_pop_valid),
        .underflow(tx_underflow)
    );

    i2s_rx_deserializer rx_inst (
        .*,
        .push(rx_push),
        .push_data(rx_push_data),
        .push_ready(rx_push_ready),
        .overflow(rx_overflow)
    );

endmodule

//--- bench/i2s_master_props.sv
/*
 * concurrent assertions on the I2S master, bound to the top level.
 * checks the AXI response hold rules, the ws timing against sck and the
 * quiet sdo line while tx is disabled. counts failures for the testbench.
 */
`timescale 1ns/1ps

module i2s_master_props (
    input logic op_clk,
    input logic reset,
    input logic sck,
    input logic ws,
    input logic sdo,
    input logic tx_enable,
    input logic awvalid,
    input logic awready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    // read by the testbench at the end of the run.
    int unsigned fail_count = 0;

    // write response stays until taken.
    bvalid_held: assert property (@(posedge op_clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
    else
    begin
        fail_count++;
        $error("bvalid dropped before bready");
    end

    // read data stays until taken.
    rvalid_held: assert property (@(posedge op_clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
    else
    begin
        fail_count++;
        $error("rvalid dropped before rready");
    end

    // ws moves together with the falling sck.
    ws_on_low_sck: assert property (@(posedge op_clk) disable iff (reset)
        $changed(ws) |-> !sck)
    else
    begin
        fail_count++;
        $error("ws changed while sck was high");
    end

    // one cycle of grace after tx_enable drops.
    sdo_quiet: assert property (@(posedge op_clk) disable iff (reset)
        (!tx_enable && !$past(tx_enable)) |-> !sdo)
    else
    begin
        fail_count++;
        $error("sdo high while tx is disabled");
    end

    // awready only answers a pending address.
    awready_on_request: assert property (@(posedge op_clk) disable iff (reset)
        awready |-> awvalid)
    else
    begin
        fail_count++;
        $error("awready without awvalid");
    end

endmodule

//--- bench/i2s_master_tb.sv
/*
 * testbench of the I2S master.
 * drives the AXI4-Lite port, loops sdo back into sdi and decodes the bus
 * from sck and ws. a table of stereo words is sent, read back through the
 * rx FIFO and compared; then underflow, overflow and FIFO limits are checked.
 */
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_master_tb;

    localparam int TABLE_LEN = 6;
    localparam int FIFO_DEPTH = 4;
    localparam int CYCLE_LIMIT = 64 * (TABLE_LEN + 12) * 4;
    localparam logic [31:0] CTRL_TX = 32'd1 << `I2S_CTRL_TX_EN;
    localparam logic [31:0] CTRL_RX = 32'd1 << `I2S_CTRL_RX_EN;
    localparam logic [31:0] CTRL_EN = 32'd1 << `I2S_CTRL_EN;
    localparam logic [31:0] STAT_UNDER = 32'd1 << `I2S_STAT_TX_UNDERFLOW;
    localparam logic [31:0] STAT_NOT_FULL = 32'd1 << `I2S_STAT_TX_NOT_FULL;
    localparam logic [31:0] STAT_OVER = 32'd1 << `I2S_STAT_RX_OVERFLOW;
    localparam logic [31:0] STAT_NOT_EMPTY = 32'd1 << `I2S_STAT_RX_NOT_EMPTY;

    logic                      op_clk = 1'b0;
    logic                      reset;
    logic                      sdi;
    logic                      sck;
    logic                      ws;
    logic                      sdo;
    logic                      awvalid;
    logic [`I2S_ADDR_BITS-1:0] awaddr;
    logic                      awready;
    logic                      wvalid;
    logic [`I2S_WORD_BITS-1:0] wdata;
    logic [3:0]                wstrb;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      bready;
    logic                      arvalid;
    logic [`I2S_ADDR_BITS-1:0] araddr;
    logic                      arready;
    logic                      rvalid;
    logic [`I2S_WORD_BITS-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rready;

    // stereo words with left in the upper half that are sent and expected back.
    logic [31:0] stim_table [TABLE_LEN] = '{
        32'h8001_7ffe, 32'ha5a5_5a5a, 32'h1234_abcd,
        32'hffff_0000, 32'h0f0f_f0f1, 32'h4c3d_0357
    };

    // bus decoder state.
    logic        sck_last;
    logic        ws_last;
    logic [15:0] left_sr;
    logic [15:0] right_sr;
    logic [15:0] dec_left [$];
    logic [15:0] dec_right [$];
    int unsigned cycle_count = 0;

    i2s_master i2s_master_inst (.*);

    bind i2s_master i2s_master_props props_inst (.*);

    always #5 op_clk = ~op_clk;

    // loopback with one register stage.
    always @(posedge op_clk)
    begin
        sdi <= sdo;
    end

    always @(posedge op_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT)
        begin
            $display("timeout: the test did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "simulation timed out");
        end
    end

    // sampled mid-cycle, where sck, ws and sdo are stable.
    always @(negedge op_clk)
    begin
        if (sck && !sck_last)
        begin
            // a bit belongs to the channel that ws selected one slot before.
            if (ws_last)
                right_sr = {right_sr[14:0], sdo};
            else
                left_sr = {left_sr[14:0], sdo};
            // ws falling means the right LSB just arrived.
            if (ws_last && !ws)
            begin
                dec_left.push_back(left_sr);
                dec_right.push_back(right_sr);
            end
            ws_last = ws;
        end
        sck_last = sck;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        @(posedge op_clk);
        reset <= 1'b1;
        repeat (8) @(posedge op_clk);
        reset <= 1'b0;
    endtask

    task automatic reset_decoder();
        @(posedge op_clk);
        sck_last = 1'b0;
        ws_last = 1'b0;
        dec_left.delete();
        dec_right.delete();
    endtask

    task automatic idle_cycles();
        repeat ($urandom % 4) @(posedge op_clk);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(posedge op_clk);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wvalid <= 1'b1;
        wstrb <= 4'hf;
        @(negedge op_clk);
        while (!awready)
            @(negedge op_clk);
        // address and data are taken in the same cycle.
        check_value("wready", 32'(wready), 32'd1);
        @(posedge op_clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        @(negedge op_clk);
        while (!bvalid)
            @(negedge op_clk);
        check_value("bresp", 32'(bresp), 32'd0);
        // hold the response a cycle before taking it.
        @(posedge op_clk);
        bready <= 1'b1;
        @(posedge op_clk);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        @(posedge op_clk);
        araddr <= addr;
        arvalid <= 1'b1;
        @(negedge op_clk);
        while (!arready)
            @(negedge op_clk);
        @(posedge op_clk);
        arvalid <= 1'b0;
        @(negedge op_clk);
        while (!rvalid)
            @(negedge op_clk);
        data = rdata;
        check_value("rresp", 32'(rresp), 32'd0);
        @(posedge op_clk);
        rready <= 1'b1;
        @(posedge op_clk);
        rready <= 1'b0;
    endtask

    task automatic wait_status(input int bit_pos);
        logic [31:0] status;
        status = '0;
        while (!status[bit_pos])
        begin
            idle_cycles();
            read_reg(`I2S_REG_STATUS, status);
        end
    endtask

    // first words must match the table, later ones are silent frames.
    task automatic check_decoded(input int count);
        @(posedge op_clk);
        if (dec_left.size() < count)
        begin
            $display("only %0d stereo words seen on the bus, %0d expected", dec_left.size(), count);
            $display("Errors found");
            $fatal(1, "missing bus words");
        end
        for (int i = 0; i < dec_left.size(); i++)
        begin
            check_value("bus left", 32'(dec_left[i]), (i < count) ? stim_table[i] >> 16 : 32'd0);
            check_value("bus right", 32'(dec_right[i]),
                        (i < count) ? 32'(stim_table[i][15:0]) : 32'd0);
        end
    endtask

    initial
    begin
        logic [31:0] value;
        int          wr_idx;
        int          rd_idx;
        void'($urandom(32'hb0ab8d57));
        reset = 1'b1;
        sdi = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        apply_reset();

        // idle state after reset.
        @(negedge op_clk);
        check_value("sck", 32'(sck), 32'd0);
        check_value("ws", 32'(ws), 32'd0);
        check_value("sdo", 32'(sdo), 32'd0);
        read_reg(`I2S_REG_STATUS, value);
        check_value("status", value, STAT_NOT_FULL);
        write_reg(`I2S_REG_CTRL, CTRL_TX | CTRL_RX);
        read_reg(`I2S_REG_CTRL, value);
        check_value("ctrl", value, CTRL_TX | CTRL_RX);

        // prefill, start, then keep both FIFOs moving.
        for (int i = 0; i < FIFO_DEPTH; i++)
            write_reg(`I2S_REG_TX_DATA, stim_table[i]);
        reset_decoder();
        write_reg(`I2S_REG_CTRL, CTRL_EN | CTRL_TX | CTRL_RX);
        wr_idx = FIFO_DEPTH;
        rd_idx = 0;
        while (rd_idx < TABLE_LEN)
        begin
            read_reg(`I2S_REG_STATUS, value);
            if (wr_idx < TABLE_LEN && value[`I2S_STAT_TX_NOT_FULL])
            begin
                write_reg(`I2S_REG_TX_DATA, stim_table[wr_idx]);
                wr_idx++;
            end
            if (value[`I2S_STAT_RX_NOT_EMPTY])
            begin
                read_reg(`I2S_REG_RX_DATA, value);
                check_value("rx data", value, stim_table[rd_idx]);
                rd_idx++;
            end
            idle_cycles();
        end
        check_decoded(TABLE_LEN);

        // after the last table word tx underflows and unread rx overflows.
        wait_status(`I2S_STAT_TX_UNDERFLOW);
        repeat (64)
        begin
            @(negedge op_clk);
            check_value("sdo", 32'(sdo), 32'd0);
        end
        wait_status(`I2S_STAT_RX_OVERFLOW);
        read_reg(`I2S_REG_STATUS, value);
        check_value("status", value, STAT_UNDER | STAT_NOT_FULL | STAT_OVER | STAT_NOT_EMPTY);
        write_reg(`I2S_REG_CTRL, CTRL_EN);
        read_reg(`I2S_REG_CTRL, value);
        check_value("ctrl", value, CTRL_EN);
        read_reg(`I2S_REG_STATUS, value);
        check_value("status", value, STAT_NOT_FULL | STAT_NOT_EMPTY);

        // overfill the tx FIFO while stopped.
        apply_reset();
        reset_decoder();
        for (int i = 0; i < TABLE_LEN; i++)
            write_reg(`I2S_REG_TX_DATA, stim_table[i]);
        read_reg(`I2S_REG_STATUS, value);
        check_value("status", value, 32'd0);
        write_reg(`I2S_REG_CTRL, CTRL_EN | CTRL_TX);
        wait_status(`I2S_STAT_TX_UNDERFLOW);
        check_decoded(FIFO_DEPTH);

        if (i2s_master_inst.props_inst.fail_count != 0)
        begin
            $display("%0d assertion failures in the bound checks",
                     i2s_master_inst.props_inst.fail_count);
            $display("Errors found");
            $fatal(1, "assertion failures");
        end
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+source
source/i2s_pkg.sv
source/i2s_regs.sv
source/i2s_sample_fifo.sv
source/i2s_frame_timer.sv
source/i2s_tx_serializer.sv
source/i2s_rx_deserializer.sv
source/i2s_master.sv
bench/i2s_master_props.sv
bench/i2s_master_tb.sv

//--- Makefile
# Verilator build and run of the I2S master testbench.
# every variable can be overridden on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= i2s_master_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
